//--- Bender.yml
package:
  name: triangle_voice

sources:
  - files:
      - synthPkg.sv
      - sampleRateTimer.sv
      - midiVoiceControl.sv
      - noteStepTable.sv
      - triangleOsc.sv
      - voiceSequencer.sv
      - voiceMac.sv
      - triangleVoice.sv
  - target: simulation
    files:
      - triangleVoiceTb.sv

//--- midiVoiceControl.sv
// MIDI message decoder holding note, velocity, pan and gate of the voice
`timescale 1ns/1ps

module midiVoiceControl import synthPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    midiValid,
    input  midiMsgT midiMsg,
    output noteT    note,
    output velT     velocity,
    output panT     pan
);

    logic forVoice;
    logic noteOn;
    logic noteOff;
    logic panCtrl;
    logic gate;
    velT  heldVel;

    assign forVoice = midiValid && (midiMsg.channel == VOICE_CHANNEL);

    // Note-on with zero velocity counts as note-off
    assign noteOn  = forVoice && (midiMsg.cmd == MIDI_CMD_NOTE_ON) && (midiMsg.data1 != '0);
    assign noteOff = forVoice &&
                     ((midiMsg.cmd == MIDI_CMD_NOTE_OFF) ||
                      ((midiMsg.cmd == MIDI_CMD_NOTE_ON) && (midiMsg.data1 == '0)));
    assign panCtrl = forVoice && (midiMsg.cmd == MIDI_CMD_CTRL) && (midiMsg.data0 == MIDI_CC_PAN);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            note <= '0;
            gate <= 1'b0;
            pan  <= PAN_CENTER;
        end else begin
            if (noteOn) begin
                note <= midiMsg.data0;
                gate <= 1'b1;
            end else if (noteOff && (midiMsg.data0 == note)) begin
                gate <= 1'b0;
            end
            if (panCtrl) begin
                pan <= midiMsg.data1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (noteOn) begin
            heldVel <= midiMsg.data1;
        end
    end

    assign velocity = gate ? heldVel : '0;

endmodule

//--- noteStepTable.sv
// Note number to triangle phase step ROM, equal tempered, clamped above the top note
`timescale 1ns/1ps

module noteStepTable import synthPkg::*; (
    input  noteT note,
    output stepT step
);

    noteT romNote;

    assign romNote = (note > NOTE_MAX) ? NOTE_MAX : note;

    always_comb begin
        case (romNote)
            7'd0:    step = 18'h00059;
            7'd1:    step = 18'h0005E;
            7'd2:    step = 18'h00064;
            7'd3:    step = 18'h0006A;
            7'd4:    step = 18'h00070;
            7'd5:    step = 18'h00077;
            7'd6:    step = 18'h0007E;
            7'd7:    step = 18'h00085;
            7'd8:    step = 18'h0008D;
            7'd9:    step = 18'h00096;
            7'd10:   step = 18'h0009F;
            7'd11:   step = 18'h000A8;
            7'd12:   step = 18'h000B2;
            7'd13:   step = 18'h000BD;
            7'd14:   step = 18'h000C8;
            7'd15:   step = 18'h000D4;
            7'd16:   step = 18'h000E1;
            7'd17:   step = 18'h000EE;
            7'd18:   step = 18'h000FC;
            7'd19:   step = 18'h0010B;
            7'd20:   step = 18'h0011B;
            7'd21:   step = 18'h0012C;
            7'd22:   step = 18'h0013E;
            7'd23:   step = 18'h00151;
            7'd24:   step = 18'h00165;
            7'd25:   step = 18'h0017A;
            7'd26:   step = 18'h00190;
            7'd27:   step = 18'h001A8;
            7'd28:   step = 18'h001C2;
            7'd29:   step = 18'h001DC;
            7'd30:   step = 18'h001F9;
            7'd31:   step = 18'h00217;
            7'd32:   step = 18'h00237;
            7'd33:   step = 18'h00258;
            7'd34:   step = 18'h0027C;
            7'd35:   step = 18'h002A2;
            7'd36:   step = 18'h002CA;
            7'd37:   step = 18'h002F4;
            7'd38:   step = 18'h00321;
            7'd39:   step = 18'h00351;
            7'd40:   step = 18'h00384;
            7'd41:   step = 18'h003B9;
            7'd42:   step = 18'h003F2;
            7'd43:   step = 18'h0042E;
            7'd44:   step = 18'h0046E;
            7'd45:   step = 18'h004B1;
            7'd46:   step = 18'h004F8;
            7'd47:   step = 18'h00544;
            7'd48:   step = 18'h00594;
            7'd49:   step = 18'h005E9;
            7'd50:   step = 18'h00643;
            7'd51:   step = 18'h006A3;
            7'd52:   step = 18'h00708;
            7'd53:   step = 18'h00773;
            7'd54:   step = 18'h007E4;
            7'd55:   step = 18'h0085C;
            7'd56:   step = 18'h008DC;
            7'd57:   step = 18'h00962;
            7'd58:   step = 18'h009F1;
            7'd59:   step = 18'h00A89;
            // Middle C
            7'd60:   step = 18'h00B29;
            7'd61:   step = 18'h00BD3;
            7'd62:   step = 18'h00C87;
            7'd63:   step = 18'h00D46;
            7'd64:   step = 18'h00E10;
            7'd65:   step = 18'h00EE6;
            7'd66:   step = 18'h00FC9;
            7'd67:   step = 18'h010B9;
            7'd68:   step = 18'h011B8;
            7'd69:   step = 18'h012C5;
            7'd70:   step = 18'h013E3;
            7'd71:   step = 18'h01512;
            7'd72:   step = 18'h01653;
            7'd73:   step = 18'h017A7;
            7'd74:   step = 18'h0190F;
            7'd75:   step = 18'h01A8C;
            7'd76:   step = 18'h01C20;
            7'd77:   step = 18'h01DCD;
            7'd78:   step = 18'h01F92;
            7'd79:   step = 18'h02173;
            7'd80:   step = 18'h02370;
            7'd81:   step = 18'h0258B;
            7'd82:   step = 18'h027C7;
            7'd83:   step = 18'h02A25;
            7'd84:   step = 18'h02CA6;
            7'd85:   step = 18'h02F4E;
            7'd86:   step = 18'h0321E;
            7'd87:   step = 18'h03519;
            7'd88:   step = 18'h03841;
            7'd89:   step = 18'h03B9A;
            7'd90:   step = 18'h03F25;
            7'd91:   step = 18'h042E6;
            7'd92:   step = 18'h046E0;
            7'd93:   step = 18'h04B17;
            7'd94:   step = 18'h04F8F;
            7'd95:   step = 18'h0544A;
            7'd96:   step = 18'h0594D;
            7'd97:   step = 18'h05E9C;
            7'd98:   step = 18'h0643C;
            7'd99:   step = 18'h06A32;
            default: step = '0;
        endcase
    end

endmodule

//--- sampleRateTimer.sv
// Sample rate divider raising a one-cycle sample tick
`timescale 1ns/1ps

module sampleRateTimer import synthPkg::*; (
    input  logic clk,
    input  logic reset,
    output logic sampleTick
);

    logic [SAMPLE_CNT_W-1:0] divCount;
    logic                    divWrap;

    assign divWrap = (divCount == SAMPLE_CNT_W'(SAMPLE_DIV - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            divCount   <= '0;
            sampleTick <= 1'b0;
        end else begin
            // Tick registered on the wrap
            sampleTick <= divWrap;
            divCount   <= divWrap ? '0 : divCount + 1'b1;
        end
    end

endmodule

//--- src.f
synthPkg.sv
sampleRateTimer.sv
midiVoiceControl.sv
noteStepTable.sv
triangleOsc.sv
voiceSequencer.sv
voiceMac.sv
triangleVoice.sv
triangleVoiceTb.sv

//--- synthPkg.sv
// Widths, typedefs, MIDI message and stereo structs, sequencer states and constants
package synthPkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int SAMPLE_W     = 18;
    localparam int MIDI_DATA_W  = 7;
    localparam int MAC_SHIFT    = 7;
    localparam int PROD_W       = SAMPLE_W + MIDI_DATA_W + 1;
    localparam int SAMPLE_DIV   = 16;
    localparam int SAMPLE_CNT_W = $clog2(SAMPLE_DIV);

    typedef logic signed [SAMPLE_W-1:0] sampleT;
    typedef logic [MIDI_DATA_W-1:0]     noteT;
    typedef logic [MIDI_DATA_W-1:0]     velT;
    typedef logic [MIDI_DATA_W-1:0]     panT;
    typedef logic [SAMPLE_W-1:0]        stepT;

    // ----------------------------------------
    // Structs and states
    // ----------------------------------------
    typedef struct packed {
        logic [3:0]             cmd;
        logic [3:0]             channel;
        logic [MIDI_DATA_W-1:0] data0;
        logic [MIDI_DATA_W-1:0] data1;
    } midiMsgT;

    typedef struct packed {
        sampleT left;
        sampleT right;
    } stereoT;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SCALE,
        LEFT,
        RIGHT,
        DONE
    } seqStateT;

    // ----------------------------------------
    // Constants
    // ----------------------------------------
    localparam logic [3:0] MIDI_CMD_NOTE_OFF = 4'h8;
    localparam logic [3:0] MIDI_CMD_NOTE_ON  = 4'h9;
    localparam logic [3:0] MIDI_CMD_CTRL     = 4'hB;
    localparam logic [3:0] VOICE_CHANNEL     = 4'h0;

    localparam logic [MIDI_DATA_W-1:0] MIDI_CC_PAN   = 7'd10;
    localparam logic [MIDI_DATA_W-1:0] MIDI_DATA_MAX = 7'd127;
    localparam logic [MIDI_DATA_W-1:0] NOTE_MAX      = 7'd99;
    localparam logic [MIDI_DATA_W-1:0] PAN_CENTER    = 7'd64;

    // Shared multiplier operations
    localparam logic [1:0] MAC_HOLD  = 2'd0;
    localparam logic [1:0] MAC_SCALE = 2'd1;
    localparam logic [1:0] MAC_LEFT  = 2'd2;
    localparam logic [1:0] MAC_RIGHT = 2'd3;

endpackage

//--- triangleOsc.sv
// Triangle accumulator with its registered direction flag
`timescale 1ns/1ps

module triangleOsc import synthPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   sampleTick,
    input  stepT   step,
    output sampleT oscValue
);

    logic       dirUp;
    logic [1:0] topBits;

    assign topBits = oscValue[SAMPLE_W-1:SAMPLE_W-2];

    // Fold near plus and minus 2^16
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dirUp <= 1'b1;
        end else if (topBits == 2'b01) begin
            dirUp <= 1'b0;
        end else if (topBits == 2'b10) begin
            dirUp <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            oscValue <= '0;
        end else if (sampleTick) begin
            if (dirUp) begin
                oscValue <= oscValue + sampleT'(step);
            end else begin
                oscValue <= oscValue - sampleT'(step);
            end
        end
    end

endmodule

//--- triangleVoice.sv
// Top level of the MIDI triangle voice
`timescale 1ns/1ps

module triangleVoice import synthPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    midiValid,
    input  midiMsgT midiMsg,
    output stereoT  sampleOut,
    output logic    sampleOutRdy
);

    logic       sampleTick;
    noteT       note;
    velT        velocity;
    panT        pan;
    stepT       step;
    sampleT     oscValue;
    logic [1:0] macOp;

    sampleRateTimer timer (
        .clk        (clk),
        .reset      (reset),
        .sampleTick (sampleTick)
    );

    midiVoiceControl control (
        .clk       (clk),
        .reset     (reset),
        .midiValid (midiValid),
        .midiMsg   (midiMsg),
        .note      (note),
        .velocity  (velocity),
        .pan       (pan)
    );

    noteStepTable stepTable (
        .note (note),
        .step (step)
    );

    triangleOsc osc (
        .clk        (clk),
        .reset      (reset),
        .sampleTick (sampleTick),
        .step       (step),
        .oscValue   (oscValue)
    );

    voiceSequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .sampleTick   (sampleTick),
        .macOp        (macOp),
        .sampleOutRdy (sampleOutRdy)
    );

    voiceMac mac (
        .clk       (clk),
        .reset     (reset),
        .macOp     (macOp),
        .oscValue  (oscValue),
        .velocity  (velocity),
        .pan       (pan),
        .sampleOut (sampleOut)
    );

endmodule

//--- triangleVoiceTb.sv
// Table-driven testbench for the MIDI triangle voice with a per-sample reference model
`timescale 1ns/1ps

module triangleVoiceTb import synthPkg::*; ();

    localparam int NUM_ENTRIES = 14;
    localparam int CLK_PERIOD  = 100;

    typedef struct packed {
        logic    hasMsg;
        midiMsgT msg;
        int      samples;
        stepT    expStep;
    } entryT;

    logic        clk;
    logic        reset;
    logic        midiValid;
    midiMsgT     midiMsg;
    stereoT      sampleOut;
    logic        sampleOutRdy;

    entryT       stimTable [NUM_ENTRIES];
    int          errorCount;
    int          checkCount;
    int          cycleCount;
    int          lastRdyCycle;
    longint      watchdogNs;
    logic        tableReady;

    // Reference model state
    sampleT      modelOsc;
    logic        modelDirUp;
    noteT        modelNote;
    velT         modelVel;
    panT         modelPan;
    logic        modelGate;

    triangleVoice UUT (
        .clk          (clk),
        .reset        (reset),
        .midiValid    (midiValid),
        .midiMsg      (midiMsg),
        .sampleOut    (sampleOut),
        .sampleOutRdy (sampleOutRdy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic checkValue(input string name, input logic signed [31:0] actual,
                              input int expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, name, actual,
                     expected);
        end
    endtask

    function automatic int randVel();
        return 1 + ($urandom % 127);
    endfunction

    function automatic int randPan();
        return $urandom % 128;
    endfunction

    task automatic addEntry(input int idx, input logic hasMsg, input logic [3:0] cmd,
                            input logic [3:0] channel, input logic [6:0] data0,
                            input logic [6:0] data1, input int samples, input stepT expStep);
        stimTable[idx].hasMsg  = hasMsg;
        stimTable[idx].msg     = {cmd, channel, data0, data1};
        stimTable[idx].samples = samples;
        stimTable[idx].expStep = expStep;
    endtask

    task automatic buildTable();
        addEntry(0,  1'b0, 4'h0, 4'h0, 7'd0, 7'd0, 8, 18'h00059);
        addEntry(1,  1'b1, MIDI_CMD_CTRL, 4'h0, MIDI_CC_PAN, 7'd127, 4, 18'h00059);
        addEntry(2,  1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd0, randVel(), 40, 18'h00059);
        addEntry(3,  1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd60, randVel(), 120, 18'h00B29);
        addEntry(4,  1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd99, 7'd127, 30, 18'h06A32);
        addEntry(5,  1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd127, randVel(), 30, 18'h06A32);
        addEntry(6,  1'b1, MIDI_CMD_CTRL, 4'h0, MIDI_CC_PAN, randPan(), 20, 18'h06A32);
        addEntry(7,  1'b1, MIDI_CMD_CTRL, 4'h0, MIDI_CC_PAN, randPan(), 20, 18'h06A32);
        // Pan on another channel, always unlike the held pan
        addEntry(8,  1'b1, MIDI_CMD_CTRL, 4'h3, MIDI_CC_PAN,
                 MIDI_DATA_MAX - stimTable[7].msg.data1, 10, 18'h06A32);
        addEntry(9,  1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd60, randVel(), 20, 18'h00B29);
        addEntry(10, 1'b1, MIDI_CMD_NOTE_OFF, 4'h0, 7'd61, 7'd64, 10, 18'h00B29);
        addEntry(11, 1'b1, MIDI_CMD_NOTE_OFF, 4'h0, 7'd60, 7'd64, 10, 18'h00B29);
        addEntry(12, 1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd60, randVel(), 10, 18'h00B29);
        addEntry(13, 1'b1, MIDI_CMD_NOTE_ON, 4'h0, 7'd60, 7'd0, 10, 18'h00B29);
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic applyModelMsg(input midiMsgT m);
        if (m.channel == VOICE_CHANNEL) begin
            if ((m.cmd == MIDI_CMD_NOTE_ON) && (m.data1 != 0)) begin
                modelNote = m.data0;
                modelVel  = m.data1;
                modelGate = 1'b1;
            end else if (((m.cmd == MIDI_CMD_NOTE_OFF) || (m.cmd == MIDI_CMD_NOTE_ON)) &&
                         (m.data0 == modelNote)) begin
                modelGate = 1'b0;
            end else if ((m.cmd == MIDI_CMD_CTRL) && (m.data0 == MIDI_CC_PAN)) begin
                modelPan = m.data1;
            end
        end
    endtask

    task automatic sendMessage(input midiMsgT m);
        midiValid = 1'b1;
        midiMsg   = m;
        applyModelMsg(m);
        @(negedge clk);
        midiValid = 1'b0;
        midiMsg   = '0;
    endtask

    task automatic waitReady();
        @(negedge clk);
        while (!sampleOutRdy) begin
            @(negedge clk);
        end
        if (lastRdyCycle >= 0) begin
            checkValue("sampleOutRdy gap", cycleCount - lastRdyCycle, SAMPLE_DIV);
        end
        lastRdyCycle = cycleCount;
    endtask

    task automatic runSample(input stepT stepVal);
        int scaledVal;
        int expLeft;
        int expRight;
        waitReady();
        // Tick applies the step, the direction follows the new value
        if (modelDirUp) begin
            modelOsc = modelOsc + sampleT'(stepVal);
        end else begin
            modelOsc = modelOsc - sampleT'(stepVal);
        end
        if (modelOsc[SAMPLE_W-1:SAMPLE_W-2] == 2'b01) begin
            modelDirUp = 1'b0;
        end else if (modelOsc[SAMPLE_W-1:SAMPLE_W-2] == 2'b10) begin
            modelDirUp = 1'b1;
        end
        scaledVal = (int'(modelOsc) * (modelGate ? int'(modelVel) : 0)) >>> MAC_SHIFT;
        expLeft   = (scaledVal * (127 - int'(modelPan))) >>> MAC_SHIFT;
        expRight  = (scaledVal * int'(modelPan)) >>> MAC_SHIFT;
        checkValue("sampleOut.left", $signed(sampleOut.left), expLeft);
        checkValue("sampleOut.right", $signed(sampleOut.right), expRight);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int totalSamples;
        void'($urandom(60));
        clk          = 1'b0;
        reset        = 1'b1;
        midiValid    = 1'b0;
        midiMsg      = '0;
        errorCount   = 0;
        checkCount   = 0;
        cycleCount   = 0;
        lastRdyCycle = -1;
        tableReady   = 1'b0;
        modelOsc     = '0;
        modelDirUp   = 1'b1;
        modelNote    = '0;
        modelVel     = '0;
        modelPan     = PAN_CENTER;
        modelGate    = 1'b0;
        buildTable();
        totalSamples = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            totalSamples += stimTable[i].samples;
        end
        watchdogNs = longint'(totalSamples + 8) * SAMPLE_DIV * CLK_PERIOD;
        tableReady = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        checkValue("sampleOutRdy", sampleOutRdy, 0);
        checkValue("sampleOut.left", $signed(sampleOut.left), 0);
        checkValue("sampleOut.right", $signed(sampleOut.right), 0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (stimTable[i].hasMsg) begin
                sendMessage(stimTable[i].msg);
            end
            repeat (stimTable[i].samples) begin
                runSample(stimTable[i].expStep);
            end
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        wait (tableReady);
        #(watchdogNs);
        $display("Timeout: the run did not finish within %0d ns, errors so far: %0d",
                 watchdogNs, errorCount);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- voiceMac.sv
// Shared multiply and scale datapath with the stereo output registers
`timescale 1ns/1ps

module voiceMac import synthPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] macOp,
    input  sampleT     oscValue,
    input  velT        velocity,
    input  panT        pan,
    output stereoT     sampleOut
);

    sampleT                   mulA;
    logic [MIDI_DATA_W-1:0]   mulB;
    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] shifted;
    sampleT                   scaled;
    sampleT                   acc;

    // ----------------------------------------
    // Operand select
    // ----------------------------------------
    always_comb begin
        case (macOp)
            MAC_SCALE: begin
                mulA = oscValue;
                mulB = velocity;
            end
            MAC_LEFT: begin
                mulA = acc;
                mulB = MIDI_DATA_MAX - pan;
            end
            MAC_RIGHT: begin
                mulA = acc;
                mulB = pan;
            end
            default: begin
                mulA = acc;
                mulB = '0;
            end
        endcase
    end

    // Unsigned MIDI operand, zero extended
    assign product = mulA * $signed({1'b0, mulB});
    assign shifted = product >>> MAC_SHIFT;
    assign scaled  = shifted[SAMPLE_W-1:0];

    always_ff @(posedge clk) begin
        if (macOp == MAC_SCALE) begin
            acc <= scaled;
        end
    end

    // ----------------------------------------
    // Output samples
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sampleOut <= '0;
        end else if (macOp == MAC_LEFT) begin
            sampleOut.left <= scaled;
        end else if (macOp == MAC_RIGHT) begin
            sampleOut.right <= scaled;
        end
    end

endmodule

//--- voiceSequencer.sv
// Per-sample FSM ordering the scale, left and right operations
`timescale 1ns/1ps

module voiceSequencer import synthPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       sampleTick,
    output logic [1:0] macOp,
    output logic       sampleOutRdy
);

    seqStateT state;
    seqStateT nextState;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // One cycle per state once started
    always_comb begin
        case (state)
            IDLE:    nextState = sampleTick ? LOAD : IDLE;
            LOAD:    nextState = SCALE;
            SCALE:   nextState = LEFT;
            LEFT:    nextState = RIGHT;
            RIGHT:   nextState = DONE;
            DONE:    nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_comb begin
        case (state)
            SCALE:   macOp = MAC_SCALE;
            LEFT:    macOp = MAC_LEFT;
            RIGHT:   macOp = MAC_RIGHT;
            default: macOp = MAC_HOLD;
        endcase
    end

    // Both channels written by now
    assign sampleOutRdy = (state == DONE);

endmodule
